//--- hw/core_pkg.sv
package core_pkg;

    // ------------------------------------------------------------------
    // Widths, depths and addresses
    // ------------------------------------------------------------------
    localparam int XLEN               = 32;
    localparam int REG_INDEX_WIDTH    = 5;
    localparam int BUFFER_DEPTH       = 4;
    // Pointer width into the buffer, depth is a power of two
    localparam int BUFFER_INDEX_WIDTH = 2;
    // Wide enough to hold BUFFER_DEPTH itself
    localparam int CREDIT_WIDTH       = 3;

    localparam logic [XLEN-1:0] RESET_ADDRESS     = 32'h0000_0000;
    localparam logic [XLEN-1:0] INSTRUCTION_BYTES = 32'd4;

    // ------------------------------------------------------------------
    // RV32I encodings of the supported subset
    // ------------------------------------------------------------------
    localparam logic [6:0] LUI    = 7'b0110111;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP     = 7'b0110011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // ------------------------------------------------------------------
    // Shared types
    // ------------------------------------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD      = 3'd0,
        ALU_SUB      = 3'd1,
        ALU_XOR      = 3'd2,
        ALU_OR       = 3'd3,
        ALU_AND      = 3'd4,
        ALU_PASS_IMM = 3'd5
    } alu_op_t;

    // Instruction memory request, answered one cycle later
    typedef struct packed {
        logic            enable;
        logic [XLEN-1:0] address;
    } imem_request_t;

    // One fetched word with its address
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instruction;
    } fetch_entry_t;

    typedef struct packed {
        logic                       valid;
        alu_op_t                    alu_op;
        logic                       read_enable_1;
        logic                       read_enable_2;
        logic [REG_INDEX_WIDTH-1:0] read_index_1;
        logic [REG_INDEX_WIDTH-1:0] read_index_2;
        logic                       write_enable;
        logic [REG_INDEX_WIDTH-1:0] write_index;
        logic [XLEN-1:0]            immediate;
    } decoded_t;

    // Payload of the retire port
    typedef struct packed {
        logic [XLEN-1:0]            pc;
        logic [REG_INDEX_WIDTH-1:0] write_index;
        logic [XLEN-1:0]            write_data;
    } retire_t;

endpackage

//--- hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      credit_return,
    output core_pkg::imem_request_t   imem_request,
    input  logic [core_pkg::XLEN-1:0] imem_data,
    output logic                      push,
    output core_pkg::fetch_entry_t    push_entry
);
    import core_pkg::*;

    // Next address to fetch
    logic [XLEN-1:0]         pc;
    logic [CREDIT_WIDTH-1:0] credits;
    logic [CREDIT_WIDTH-1:0] credits_next;
    // Request on the memory port this cycle
    logic                    issue;
    // Request of the previous cycle, pairs the returned word with its pc
    imem_request_t           last_request;

    // A fetch goes out in every cycle that holds a credit
    assign issue = !reset && (credits != '0);

    // Current request pays its credit, a pop gives one back
    always_comb
    begin
        credits_next = credits + CREDIT_WIDTH'(credit_return)
                     - CREDIT_WIDTH'(issue);
    end

    // ------------------------------------------------------------------
    // Program counter, credits and request registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc                  <= RESET_ADDRESS;
            credits             <= CREDIT_WIDTH'(BUFFER_DEPTH);
            last_request.enable <= 1'b0;
        end
        else
        begin
            credits      <= credits_next;
            // Step only when the address actually goes out
            if (issue)
                pc <= pc + INSTRUCTION_BYTES;
            last_request <= imem_request;
        end
    end

    assign imem_request.enable  = issue;
    assign imem_request.address = pc;

    // Memory data is valid one cycle after an enabled request
    assign push               = last_request.enable;
    assign push_entry.pc          = last_request.address;
    assign push_entry.instruction = imem_data;

endmodule

//--- hw/instruction_buffer.sv
`timescale 1ns/1ps

module instruction_buffer
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  core_pkg::fetch_entry_t push_entry,
    input  logic                   pop,
    output logic                   not_empty,
    output core_pkg::fetch_entry_t head_entry
);
    import core_pkg::*;

    fetch_entry_t                  slots [BUFFER_DEPTH];
    logic [BUFFER_INDEX_WIDTH-1:0] write_ptr;
    logic [BUFFER_INDEX_WIDTH-1:0] read_ptr;
    // Occupancy, 0 to BUFFER_DEPTH
    logic [CREDIT_WIDTH-1:0]       count;

    // ------------------------------------------------------------------
    // Storage, no reset on the payload
    // ------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (push)
            slots[write_ptr] <= push_entry;
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            write_ptr <= '0;
            read_ptr  <= '0;
            count     <= '0;
        end
        else
        begin
            if (push)
                write_ptr <= write_ptr + 1'b1;
            if (pop)
                read_ptr <= read_ptr + 1'b1;
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign not_empty  = (count != '0);
    // Oldest entry
    assign head_entry = slots[read_ptr];

endmodule

//--- hw/instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder
(
    input  logic [core_pkg::XLEN-1:0] instruction,
    output core_pkg::decoded_t        decoded
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    always_comb
    begin
        decoded              = '0;
        decoded.alu_op       = ALU_ADD;
        // Register fields sit in the same place for every format
        decoded.read_index_1 = instruction[19:15];
        decoded.read_index_2 = instruction[24:20];
        decoded.write_index  = instruction[11:7];

        case (opcode)
            LUI:
            begin
                // U-type, upper 20 bits with the low 12 cleared
                decoded.valid        = 1'b1;
                decoded.alu_op       = ALU_PASS_IMM;
                decoded.write_enable = 1'b1;
                decoded.immediate    = {instruction[31:12], 12'b0};
            end
            OP_IMM:
            begin
                // I-type, sign extended 12 bit immediate
                decoded.valid         = 1'b1;
                decoded.read_enable_1 = 1'b1;
                decoded.write_enable  = 1'b1;
                decoded.immediate     = {{20{instruction[31]}}, instruction[31:20]};
                case (funct3)
                    F3_ADD_SUB: decoded.alu_op = ALU_ADD;
                    F3_XOR:     decoded.alu_op = ALU_XOR;
                    F3_OR:      decoded.alu_op = ALU_OR;
                    F3_AND:     decoded.alu_op = ALU_AND;
                    default:    decoded.valid  = 1'b0;
                endcase
            end
            OP:
            begin
                decoded.valid         = 1'b1;
                decoded.read_enable_1 = 1'b1;
                decoded.read_enable_2 = 1'b1;
                decoded.write_enable  = 1'b1;
                // SUB is the only kept encoding with funct7 set
                if (funct7 == F7_SUB && funct3 == F3_ADD_SUB)
                    decoded.alu_op = ALU_SUB;
                else if (funct7 == F7_BASE)
                begin
                    case (funct3)
                        F3_ADD_SUB: decoded.alu_op = ALU_ADD;
                        F3_XOR:     decoded.alu_op = ALU_XOR;
                        F3_OR:      decoded.alu_op = ALU_OR;
                        F3_AND:     decoded.alu_op = ALU_AND;
                        default:    decoded.valid  = 1'b0;
                    endcase
                end
                else
                    decoded.valid = 1'b0;
            end
            default:
                decoded.valid = 1'b0;
        endcase

        // Unsupported encodings read and write nothing
        if (!decoded.valid)
        begin
            decoded.read_enable_1 = 1'b0;
            decoded.read_enable_2 = 1'b0;
            decoded.write_enable  = 1'b0;
        end
    end

endmodule

//--- hw/register_file.sv
`timescale 1ns/1ps

module register_file
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [core_pkg::REG_INDEX_WIDTH-1:0] read_index_1,
    input  logic [core_pkg::REG_INDEX_WIDTH-1:0] read_index_2,
    output logic [core_pkg::XLEN-1:0]            read_data_1,
    output logic [core_pkg::XLEN-1:0]            read_data_2,
    input  logic                                 write_enable,
    input  logic [core_pkg::REG_INDEX_WIDTH-1:0] write_index,
    input  logic [core_pkg::XLEN-1:0]            write_data
);
    import core_pkg::*;

    logic [XLEN-1:0] registers [2**REG_INDEX_WIDTH];

    // Writes land on the clock, x0 is never written
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 2**REG_INDEX_WIDTH; i++)
                registers[i] <= '0;
        end
        else if (write_enable && write_index != '0)
            registers[write_index] <= write_data;
    end

    // Combinational reads, x0 forced to zero
    assign read_data_1 = (read_index_1 == '0) ? '0 : registers[read_index_1];
    assign read_data_2 = (read_index_2 == '0) ? '0 : registers[read_index_2];

endmodule

//--- hw/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   not_empty,
    input  core_pkg::fetch_entry_t head_entry,
    output logic                   pop,
    output logic                   credit_return,
    output logic                   retire_valid,
    input  logic                   retire_ready,
    output core_pkg::retire_t      retire
);
    import core_pkg::*;

    // Execute stage contents, operands already forwarded
    typedef struct packed {
        logic                       valid;
        logic [XLEN-1:0]            pc;
        alu_op_t                    alu_op;
        logic                       write_enable;
        logic [REG_INDEX_WIDTH-1:0] write_index;
        logic [XLEN-1:0]            operand_a;
        logic [XLEN-1:0]            operand_b;
    } execute_stage_t;

    decoded_t        decoded;
    logic [XLEN-1:0] file_data_1;
    logic [XLEN-1:0] file_data_2;
    logic [XLEN-1:0] source_1;
    logic [XLEN-1:0] source_2;
    logic [XLEN-1:0] alu_result;
    execute_stage_t  ex_q;
    logic            wb_valid;
    retire_t         wb_q;
    logic            stall;

    // Newest value first, execute stage, then writeback, then the file
    function automatic logic [XLEN-1:0] forward
    (
        input logic [REG_INDEX_WIDTH-1:0] index,
        input logic [XLEN-1:0]            file_data
    );
        if (index != '0 && ex_q.valid && ex_q.write_enable && ex_q.write_index == index)
            return alu_result;
        else if (index != '0 && wb_valid && wb_q.write_index == index)
            return wb_q.write_data;
        else
            return file_data;
    endfunction

    // ------------------------------------------------------------------
    // Decode and operand read for the head entry
    // ------------------------------------------------------------------
    instruction_decoder u_decoder
    (
        .instruction (head_entry.instruction),
        .decoded     (decoded)
    );

    // Written only in the retire handshake cycle
    register_file u_register_file
    (
        .clk          (clk),
        .reset        (reset),
        .read_index_1 (decoded.read_index_1),
        .read_index_2 (decoded.read_index_2),
        .read_data_1  (file_data_1),
        .read_data_2  (file_data_2),
        .write_enable (wb_valid && retire_ready),
        .write_index  (wb_q.write_index),
        .write_data   (wb_q.write_data)
    );

    always_comb
    begin
        source_1 = forward(decoded.read_index_1, file_data_1);
        source_2 = forward(decoded.read_index_2, file_data_2);
    end

    // Retire back-pressure freezes both stages
    assign stall         = wb_valid && !retire_ready;
    assign pop           = not_empty && !stall;
    // Every pop frees one buffer slot
    assign credit_return = pop;

    // ------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------
    always_comb
    begin
        case (ex_q.alu_op)
            ALU_ADD:      alu_result = ex_q.operand_a + ex_q.operand_b;
            ALU_SUB:      alu_result = ex_q.operand_a - ex_q.operand_b;
            ALU_XOR:      alu_result = ex_q.operand_a ^ ex_q.operand_b;
            ALU_OR:       alu_result = ex_q.operand_a | ex_q.operand_b;
            ALU_AND:      alu_result = ex_q.operand_a & ex_q.operand_b;
            ALU_PASS_IMM: alu_result = ex_q.operand_b;
            default:      alu_result = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // Execute and writeback stage registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex_q.valid <= 1'b0;
            wb_valid   <= 1'b0;
        end
        else if (!stall)
        begin
            // Invalid decode leaves an empty slot
            ex_q.valid        <= pop && decoded.valid;
            ex_q.pc           <= head_entry.pc;
            ex_q.alu_op       <= decoded.alu_op;
            ex_q.write_enable <= decoded.write_enable;
            ex_q.write_index  <= decoded.write_index;
            ex_q.operand_a    <= decoded.read_enable_1 ? source_1 : '0;
            // Immediate stands in for rs2 on OP-IMM and LUI
            ex_q.operand_b    <= decoded.read_enable_2 ? source_2 : decoded.immediate;

            wb_valid          <= ex_q.valid && ex_q.write_enable;
            wb_q.pc           <= ex_q.pc;
            wb_q.write_index  <= ex_q.write_index;
            wb_q.write_data   <= alu_result;
        end
    end

    assign retire_valid = wb_valid;
    assign retire       = wb_q;

endmodule

//--- hw/core_top.sv
`timescale 1ns/1ps

module core_top
(
    input  logic                      clk,
    input  logic                      reset,
    output core_pkg::imem_request_t   imem_request,
    input  logic [core_pkg::XLEN-1:0] imem_data,
    output logic                      retire_valid,
    input  logic                      retire_ready,
    output core_pkg::retire_t         retire
);
    import core_pkg::*;

    // Fetch to buffer
    logic         push;
    fetch_entry_t push_entry;
    // Buffer to execute
    logic         not_empty;
    fetch_entry_t head_entry;
    logic         pop;
    // Execute back to fetch
    logic         credit_return;

    // ------------------------------------------------------------------
    // Producer, buffer and consumer
    // ------------------------------------------------------------------
    fetch_unit u_fetch
    (
        .clk           (clk),
        .reset         (reset),
        .credit_return (credit_return),
        .imem_request  (imem_request),
        .imem_data     (imem_data),
        .push          (push),
        .push_entry    (push_entry)
    );

    instruction_buffer u_buffer
    (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .not_empty  (not_empty),
        .head_entry (head_entry)
    );

    execute_unit u_execute
    (
        .clk           (clk),
        .reset         (reset),
        .not_empty     (not_empty),
        .head_entry    (head_entry),
        .pop           (pop),
        .credit_return (credit_return),
        .retire_valid  (retire_valid),
        .retire_ready  (retire_ready),
        .retire        (retire)
    );

endmodule

//--- testbench/core_properties.sv
`timescale 1ns/1ps

module core_properties
(
    input logic                              clk,
    input logic                              reset,
    input core_pkg::imem_request_t           imem_request,
    input logic                              push,
    input logic [core_pkg::CREDIT_WIDTH-1:0] occupancy,
    input logic                              retire_valid,
    input logic                              retire_ready,
    input core_pkg::retire_t                 retire
);
    import core_pkg::*;

    // Firing count per property
    int unsigned stall_failures   = 0;
    int unsigned credit_failures  = 0;
    int unsigned address_failures = 0;

    // Address of the last enabled request
    logic [XLEN-1:0] last_address;
    logic            request_seen;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            request_seen <= 1'b0;
            last_address <= RESET_ADDRESS;
        end
        else if (imem_request.enable)
        begin
            request_seen <= 1'b1;
            last_address <= imem_request.address;
        end
    end

    // ------------------------------------------------------------------
    // Retire port, credit accounting and fetch order
    // ------------------------------------------------------------------
    // Stalled payload stays put
    assert property (@(posedge clk) disable iff (reset)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire))
    else
    begin
        $error("retire payload changed while stalled");
        stall_failures++;
    end

    // Word returning now plus request on the bus plus stored entries
    assert property (@(posedge clk) disable iff (reset)
        (int'(occupancy) + int'(push) + int'(imem_request.enable)) <= BUFFER_DEPTH)
    else
    begin
        $error("fetches in flight plus buffer occupancy exceed the depth");
        credit_failures++;
    end

    assert property (@(posedge clk) disable iff (reset)
        imem_request.enable && request_seen
        |-> imem_request.address == last_address + INSTRUCTION_BYTES)
    else
    begin
        $error("request address did not step by one instruction");
        address_failures++;
    end

endmodule

bind core_top core_properties u_properties
(
    .clk          (clk),
    .reset        (reset),
    .imem_request (imem_request),
    .push         (push),
    .occupancy    (u_buffer.count),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire       (retire)
);

//--- testbench/core_tb.sv
`timescale 1ns/1ps

module core_tb;
    import core_pkg::*;

    // One program row with the result it must retire
    typedef struct packed {
        logic [XLEN-1:0]            instruction;
        logic                       retires;
        logic [REG_INDEX_WIDTH-1:0] write_index;
        logic [XLEN-1:0]            write_data;
    } program_row_t;

    localparam int              NUM_ROWS       = 17;
    localparam int              RETIRE_TIMEOUT = 200;
    localparam int              TAIL_CYCLES    = 40;
    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP            = 32'h0000_0013;

    // Columns: instruction, retires, write index, write data
    localparam program_row_t PROGRAM_TABLE [NUM_ROWS] = '{
        '{32'hFFB0_0093, 1'b1, 5'd1,  32'hFFFF_FFFB},  // ADDI x1, x0, -5
        '{32'hFFF0_C113, 1'b1, 5'd2,  32'h0000_0004},  // XORI x2, x1, -1
        '{32'h8001_6193, 1'b1, 5'd3,  32'hFFFF_F804},  // ORI  x3, x2, -2048
        '{32'hFF00_F213, 1'b1, 5'd4,  32'hFFFF_FFF0},  // ANDI x4, x1, -16
        '{32'h1234_52B7, 1'b1, 5'd5,  32'h1234_5000},  // LUI  x5, 0x12345
        '{32'h6782_8313, 1'b1, 5'd6,  32'h1234_5678},  // ADDI x6, x5, 0x678
        '{32'h0053_03B3, 1'b1, 5'd7,  32'h2468_A678},  // ADD  x7, x6, x5
        '{32'h4013_8433, 1'b1, 5'd8,  32'h2468_A67D},  // SUB  x8, x7, x1
        '{32'h0074_44B3, 1'b1, 5'd9,  32'h0000_0005},  // XOR  x9, x8, x7
        '{32'h0084_E533, 1'b1, 5'd10, 32'h2468_A67D},  // OR   x10, x9, x8
        '{32'h0045_75B3, 1'b1, 5'd11, 32'h2468_A670},  // AND  x11, x10, x4
        '{32'h0075_8013, 1'b1, 5'd0,  32'h2468_A677},  // ADDI x0, x11, 7
        '{32'h0010_0633, 1'b1, 5'd12, 32'hFFFF_FFFB},  // ADD  x12, x0, x1
        '{32'h0000_1697, 1'b0, 5'd0,  32'h0000_0000},  // AUIPC, dropped
        '{32'h4036_0733, 1'b1, 5'd14, 32'h0000_07F7},  // SUB  x14, x12, x3
        '{32'h7FF7_4793, 1'b1, 5'd15, 32'h0000_0008},  // XORI x15, x14, 0x7FF
        '{32'h00E7_8833, 1'b1, 5'd16, 32'h0000_07FF}   // ADD  x16, x15, x14
    };

    logic            clk;
    logic            reset;
    imem_request_t   imem_request;
    logic [XLEN-1:0] imem_data    = '0;
    logic            retire_valid;
    logic            retire_ready = 1'b0;
    retire_t         retire;

    // Request monitor state
    logic [XLEN-1:0] next_request_address = RESET_ADDRESS;
    imem_request_t   expected_request;
    // Set while the first cycle after reset is still ahead
    logic            reset_just_released  = 1'b0;

    core_top u_dut
    (
        .clk          (clk),
        .reset        (reset),
        .imem_request (imem_request),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_retire(input retire_t actual, input retire_t expected);
        if (actual !== expected)
        begin
            $display("[ERROR] retire: expected pc %h index %h data %h, got pc %h index %h data %h",
                     expected.pc, expected.write_index, expected.write_data,
                     actual.pc, actual.write_index, actual.write_data);
            abort_run();
        end
    endtask

    task automatic check_request(input imem_request_t actual, input imem_request_t expected);
        if (actual !== expected)
        begin
            $display("[ERROR] imem_request: expected enable %h address %h, got enable %h address %h",
                     expected.enable, expected.address, actual.enable, actual.address);
            abort_run();
        end
    endtask

    // Program words, NOPs past the end of the table
    function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] address);
        if (address < NUM_ROWS * INSTRUCTION_BYTES)
            return PROGRAM_TABLE[int'(address / INSTRUCTION_BYTES)].instruction;
        else
            return NOP;
    endfunction

    function automatic int assertion_failures();
        return u_dut.u_properties.stall_failures + u_dut.u_properties.credit_failures
             + u_dut.u_properties.address_failures;
    endfunction

    // Returns at the falling edge before a retire handshake
    task automatic wait_for_retire(input int row);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
            if (cycles > RETIRE_TIMEOUT)
            begin
                $display("Timeout waiting for the retirement of program row %0d", row);
                abort_run();
            end
        end
        while (!(retire_valid && retire_ready));
    endtask

    // Only NOP retirements may follow the program
    task automatic watch_tail();
        for (int cycle = 0; cycle < TAIL_CYCLES; cycle++)
        begin
            @(negedge clk);
            if (retire_valid && retire_ready && retire.write_index != '0)
            begin
                $display("Unexpected retirement to a nonzero register at pc %h", retire.pc);
                abort_run();
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Memory model, retire back-pressure and monitors
    // ------------------------------------------------------------------
    // Data one cycle after an enabled request
    always @(posedge clk)
    begin
        if (imem_request.enable)
            imem_data <= fetch_word(imem_request.address);
    end

    // Ready low about a third of the time
    always @(posedge clk)
    begin
        if (reset)
            retire_ready <= 1'b0;
        else
            retire_ready <= ($urandom % 3) != 0;
    end

    // Requests sampled mid cycle, the first one due right after reset
    always @(negedge clk)
    begin
        if (reset)
        begin
            expected_request.enable  = 1'b0;
            expected_request.address = RESET_ADDRESS;
            check_request(imem_request, expected_request);
            if (retire_valid !== 1'b0)
            begin
                $display("retire_valid went high during reset");
                abort_run();
            end
            reset_just_released <= 1'b1;
        end
        else if (imem_request.enable || reset_just_released)
        begin
            expected_request.enable  = 1'b1;
            expected_request.address = next_request_address;
            check_request(imem_request, expected_request);
            next_request_address <= next_request_address + INSTRUCTION_BYTES;
            reset_just_released  <= 1'b0;
        end
    end

    always @(negedge clk)
    begin
        if (assertion_failures() != 0)
        begin
            $display("A bound assertion on core_top fired");
            abort_run();
        end
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial
    begin
        retire_t expected;
        void'($urandom(40527));
        reset = 1'b1;
        repeat (8)
            @(posedge clk);
        reset <= 1'b0;

        // Rows retire in order, dropped opcodes leave no trace
        for (int row = 0; row < NUM_ROWS; row++)
        begin
            if (PROGRAM_TABLE[row].retires)
            begin
                expected.pc          = XLEN'(row) * INSTRUCTION_BYTES;
                expected.write_index = PROGRAM_TABLE[row].write_index;
                expected.write_data  = PROGRAM_TABLE[row].write_data;
                wait_for_retire(row);
                check_retire(retire, expected);
            end
        end

        watch_tail();

        if (assertion_failures() != 0)
            abort_run();
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- sources.f
hw/core_pkg.sv
hw/fetch_unit.sv
hw/instruction_buffer.sv
hw/instruction_decoder.sv
hw/register_file.sv
hw/execute_unit.sv
hw/core_top.sv
testbench/core_properties.sv
testbench/core_tb.sv

//--- Makefile
VERILATOR  = verilator
TOP        = core_tb
FILELIST   = sources.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Simulation passed
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulation status is taken from the log, not from the executable
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
